// ==== hdl/neoFrameSequencer.sv ====
`timescale 1ns/1ps

module neoFrameSequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  neoRegPkg::ctrlRegT     ctrl,
  output neoTypesPkg::bufAddrT   streamAddr,
  output neoTypesPkg::seqStateT  state,
  output neoTypesPkg::channelIxT channelIx,
  output neoTypesPkg::bitIxT     pixelBitIx,
  output neoTypesPkg::slotIxT    slotIx
);

  neoTypesPkg::latchCntT latchCnt;
  neoTypesPkg::pixelIxT  pixelIx;

  logic latchDone; // last cycle of the low gap
  logic slotDone;  // last slot of a bit
  logic bitDone;   // last bit of a channel
  logic chanDone;  // blue is the last channel of a pixel
  logic pixDone;   // the pixel in flight is the last one of the frame

  assign latchDone = (latchCnt == neoTypesPkg::latchCntT'(neoTypesPkg::latchCycles - 1));
  assign slotDone  = (slotIx == 3'd7);
  assign bitDone   = (pixelBitIx == 3'd7);
  assign chanDone  = (channelIx == 2'd2);
  assign pixDone   = (pixelIx == ctrl.lastPixel);

  // 32-bit mode skips the unused fourth byte, 8-bit mode has one byte per pixel
  assign streamAddr = ctrl.mode32 ? {pixelIx[3:0], channelIx} : pixelIx;

  always_ff @(posedge clk) begin
    if (rst || !ctrl.run) begin
      // dropping run stops the strip on the next edge, mid-frame or not
      state      <= neoTypesPkg::stIdle;
      latchCnt   <= '0;
      pixelIx    <= '0;
      channelIx  <= '0;
      pixelBitIx <= '0;
      slotIx     <= '0;
    end else begin
      case (state)
        neoTypesPkg::stIdle: begin
          state    <= neoTypesPkg::stLatch; // a gap always comes before the first frame
          latchCnt <= '0;
        end
        neoTypesPkg::stLatch: begin
          latchCnt   <= latchCnt + 1'b1;
          pixelIx    <= '0;
          channelIx  <= '0;
          pixelBitIx <= '0;
          slotIx     <= '0;
          if (latchDone) state <= neoTypesPkg::stTransmit;
        end
        neoTypesPkg::stTransmit: begin
          slotIx <= slotIx + 1'b1; // one slot per cycle, wraps after 8
          if (slotDone) begin
            pixelBitIx <= pixelBitIx + 1'b1;
            if (bitDone) begin
              if (chanDone) begin
                channelIx <= '0;
                if (pixDone) begin
                  // frame finished, latch and then start over from pixel 0
                  state    <= neoTypesPkg::stLatch;
                  latchCnt <= '0;
                  pixelIx  <= '0;
                end else begin
                  pixelIx <= pixelIx + 1'b1;
                end
              end else begin
                channelIx <= channelIx + 1'b1;
              end
            end
          end
        end
        default: state <= neoTypesPkg::stIdle;
      endcase
    end
  end

  // the channel counter must wrap after blue and never land on the unused byte
  noFourthChannel: assert property (@(posedge clk) disable iff (rst)
    state == neoTypesPkg::stTransmit |-> channelIx != 2'd3)
    else $error("channelIx reached 3 during transmit");

endmodule

// ==== hdl/neoPixelBuffer.sv ====
`timescale 1ns/1ps

module neoPixelBuffer (
  input  logic                   clk,
  input  logic                   we,
  input  neoTypesPkg::bufAddrT   hostAddr,
  input  neoTypesPkg::pixelByteT hostWdata,
  output neoTypesPkg::pixelByteT hostRdata,
  input  neoTypesPkg::bufAddrT   streamAddr,
  output neoTypesPkg::pixelByteT streamByte
);

  // pixel bytes only change through host writes
  neoTypesPkg::pixelByteT mem [0:neoTypesPkg::bufferEnd];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[hostAddr] <= hostWdata;
    end
  end

  // both read ports are asynchronous, the stream side never waits on the host
  assign hostRdata  = mem[hostAddr];
  assign streamByte = mem[streamAddr]; // addressed by the sequencer counters

endmodule

// ==== hdl/neoPixelTop.sv ====
`timescale 1ns/1ps

module neoPixelTop (
  input  logic               clk,  // eight clocks per led bit
  input  logic               rst,
  input  neoRegPkg::hostReqT hostIn,
  output neoRegPkg::hostRspT hostOut,
  output logic               neoData
);

  neoRegPkg::ctrlRegT     ctrl;
  logic                   bufWe;
  neoTypesPkg::bufAddrT   bufAddr;
  neoTypesPkg::pixelByteT bufWdata;
  neoTypesPkg::pixelByteT bufRdata;
  neoTypesPkg::bufAddrT   streamAddr;
  neoTypesPkg::pixelByteT streamByte;
  neoTypesPkg::seqStateT  state;
  neoTypesPkg::channelIxT channelIx;
  neoTypesPkg::bitIxT     pixelBitIx;
  neoTypesPkg::slotIxT    slotIx;

  neoRegBlock regBlock (
    .clk      (clk),
    .rst      (rst),
    .hostIn   (hostIn),
    .hostOut  (hostOut),
    .ctrl     (ctrl),
    .bufWe    (bufWe),
    .bufAddr  (bufAddr),
    .bufWdata (bufWdata),
    .bufRdata (bufRdata)
  );

  // host side writes and reads, stream side only reads
  neoPixelBuffer pixelBuffer (
    .clk        (clk),
    .we         (bufWe),
    .hostAddr   (bufAddr),
    .hostWdata  (bufWdata),
    .hostRdata  (bufRdata),
    .streamAddr (streamAddr),
    .streamByte (streamByte)
  );

  neoFrameSequencer frameSequencer (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .streamAddr (streamAddr),
    .state      (state),
    .channelIx  (channelIx),
    .pixelBitIx (pixelBitIx),
    .slotIx     (slotIx)
  );

  neoStreamEncoder streamEncoder (
    .ctrl       (ctrl),
    .streamByte (streamByte),
    .state      (state),
    .channelIx  (channelIx),
    .pixelBitIx (pixelBitIx),
    .slotIx     (slotIx),
    .neoData    (neoData)
  );

endmodule

// ==== hdl/neoRegBlock.sv ====
`timescale 1ns/1ps

module neoRegBlock (
  input  logic                   clk,
  input  logic                   rst,
  input  neoRegPkg::hostReqT     hostIn,
  output neoRegPkg::hostRspT     hostOut,
  output neoRegPkg::ctrlRegT     ctrl,
  output logic                   bufWe,
  output neoTypesPkg::bufAddrT   bufAddr,
  output neoTypesPkg::pixelByteT bufWdata,
  input  neoTypesPkg::pixelByteT bufRdata
);

  typedef enum logic {
    hsIdle,  // waiting for req
    hsAcked  // ack high, waiting for req to drop
  } hsStateT;

  hsStateT                hsState;
  neoTypesPkg::pixelByteT rdataQ;
  neoTypesPkg::pixelByteT readValue;
  logic                   accept;  // the single cycle in which an access is carried out
  logic                   isCtrl;

  assign accept = (hsState == hsIdle) && hostIn.req;
  assign isCtrl = hostIn.addr[6];

  // the buffer sees the host address directly and writes on the accept edge
  assign bufWe    = accept && hostIn.we && !isCtrl;
  assign bufAddr  = neoTypesPkg::bufAddrT'(hostIn.addr[5:0]);
  assign bufWdata = hostIn.wdata;

  always_comb begin
    readValue = bufRdata; // buffer reads are asynchronous so the byte is ready now
    if (isCtrl) begin
      if (hostIn.addr == neoRegPkg::ctrlAddr) begin
        readValue = {6'b0, ctrl.mode32, ctrl.run};
      end else if (hostIn.addr == neoRegPkg::lastPixelAddr) begin
        readValue = {2'b0, ctrl.lastPixel};
      end else begin
        readValue = '0; // unmapped control addresses read as zero
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hsState <= hsIdle;
      ctrl    <= '0;
    end else begin
      case (hsState)
        hsIdle: if (hostIn.req) begin
          hsState <= hsAcked;
          if (hostIn.we && hostIn.addr == neoRegPkg::ctrlAddr) begin
            ctrl.run    <= hostIn.wdata[neoRegPkg::ctrlRunBit];
            ctrl.mode32 <= hostIn.wdata[neoRegPkg::ctrlMode32Bit];
          end
          if (hostIn.we && hostIn.addr == neoRegPkg::lastPixelAddr) begin
            ctrl.lastPixel <= hostIn.wdata[5:0];
          end
        end
        hsAcked: if (!hostIn.req) hsState <= hsIdle; // ack follows req down one cycle later
        default: hsState <= hsIdle;
      endcase
    end
  end

  // read data is captured once per access and held for the whole ack phase
  always_ff @(posedge clk) begin
    if (accept) rdataQ <= readValue;
  end

  always_comb begin
    hostOut.ack   = (hsState == hsAcked);
    hostOut.rdata = rdataQ;
  end

  // the handshake may only answer a request that was already pending
  ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
    $rose(hostOut.ack) |-> $past(hostIn.req))
    else $error("ack rose without a pending req");

endmodule

// ==== hdl/neoRegPkg.sv ====
package neoRegPkg;

  // bit 6 picks the control space, bits 5:0 pick a buffer byte
  typedef logic [6:0] hostAddrT;

  localparam hostAddrT ctrlAddr      = 7'd64; // run and mode32
  localparam hostAddrT lastPixelAddr = 7'd65; // index of the last pixel in a frame

  // bit positions inside a write to ctrlAddr
  localparam int ctrlRunBit    = 0;
  localparam int ctrlMode32Bit = 1;

  typedef struct packed {
    logic                  req;   // held high until ack is seen
    logic                  we;
    hostAddrT              addr;
    neoTypesPkg::pixelByteT wdata;
  } hostReqT;

  typedef struct packed {
    logic                  ack;
    neoTypesPkg::pixelByteT rdata; // valid while ack is high for reads
  } hostRspT;

  typedef struct packed {
    logic                 run;       // frames repeat while this is set
    logic                 mode32;    // 4 bytes per pixel when set, 1 byte when clear
    neoTypesPkg::pixelIxT lastPixel;
  } ctrlRegT;

endpackage

// ==== hdl/neoStreamEncoder.sv ====
`timescale 1ns/1ps

module neoStreamEncoder (
  input  neoRegPkg::ctrlRegT     ctrl,
  input  neoTypesPkg::pixelByteT streamByte,
  input  neoTypesPkg::seqStateT  state,
  input  neoTypesPkg::channelIxT channelIx,
  input  neoTypesPkg::bitIxT     pixelBitIx,
  input  neoTypesPkg::slotIxT    slotIx,
  output logic                   neoData
);

  neoTypesPkg::pixelByteT chanValue;  // 8-bit value of the channel being sent
  logic                   chanBit;    // the bit currently on the wire
  logic [7:0]             pattern;    // slot pattern for that bit
  logic [2:0]             green8;     // fields of a packed 8-bit pixel
  logic [2:0]             red8;
  logic [1:0]             blue8;

  // packed layout is blue 7:6, green 5:3, red 2:0
  assign blue8  = streamByte[7:6];
  assign green8 = streamByte[5:3];
  assign red8   = streamByte[2:0];

  always_comb begin
    if (ctrl.mode32) begin
      chanValue = streamByte; // the sequencer already addresses the right byte
    end else begin
      // left-justify each field and repeat it so full scale stays full scale
      case (channelIx)
        2'd0:    chanValue = {green8, green8, green8[2:1]};
        2'd1:    chanValue = {red8, red8, red8[2:1]};
        2'd2:    chanValue = {blue8, blue8, blue8, blue8};
        default: chanValue = '0;
      endcase
    end
  end

  // bit index 0 is the msb, which goes out first
  assign chanBit = chanValue[3'd7 - pixelBitIx];
  assign pattern = chanBit ? neoTypesPkg::patternOne : neoTypesPkg::patternZero;

  always_comb begin
    if (state == neoTypesPkg::stTransmit && ctrl.run) begin
      neoData = pattern[slotIx]; // follows the slot counter in the same cycle
    end else begin
      neoData = 1'b0; // idle and latch both keep the line low
    end
  end

endmodule

// ==== hdl/neoTypesPkg.sv ====
package neoTypesPkg;

  // one byte of the pixel buffer, either a colour channel or a packed 8-bit pixel
  typedef logic [7:0] pixelByteT;

  typedef logic [5:0] bufAddrT; // byte address into the 64-byte buffer
  localparam bufAddrT bufferEnd = 6'd63; // 16 pixels in 32-bit mode, 64 in 8-bit mode

  typedef logic [5:0] pixelIxT;   // pixel index inside a frame
  typedef logic [1:0] channelIxT; // 0 green, 1 red, 2 blue on the wire
  typedef logic [2:0] bitIxT;     // 0 is the msb, which goes out first
  typedef logic [2:0] slotIxT;    // eight pattern slots per led bit

  // the gap between frames, wide enough to count up to latchCycles
  typedef logic [8:0] latchCntT;
  localparam int latchCycles = 400;

  // slot patterns are indexed by slotIx, so slot 0 sits in bit 0
  localparam logic [7:0] patternOne  = 8'b0001_1111; // high for 5 slots
  localparam logic [7:0] patternZero = 8'b0000_0011; // high for 2 slots

  typedef enum logic [1:0] {
    stIdle,     // run clear, line held low
    stLatch,    // low gap that latches the strip
    stTransmit  // walking pixels, channels, bits and slots
  } seqStateT;

endpackage

// ==== project.f ====
hdl/neoTypesPkg.sv
hdl/neoRegPkg.sv
hdl/neoPixelBuffer.sv
hdl/neoRegBlock.sv
hdl/neoFrameSequencer.sv
hdl/neoStreamEncoder.sv
hdl/neoPixelTop.sv
testbench/neoPixelTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the simulation, run it, and pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module neoPixelTb -f project.f -o neoPixelSim \
  && ./obj_dir/neoPixelSim | tee sim.log
grep -qx "Done: no errors" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== testbench/neoPixelTb.sv ====
`timescale 1ns/1ps

module neoPixelTb;

  localparam int testPixels [6] = '{0, 0, 4, 8, 4, 16}; // pixels sent by each test

  logic               clk;
  logic               rst;
  neoRegPkg::hostReqT hostIn;
  neoRegPkg::hostRspT hostOut;
  logic               neoData;

  logic [7:0]  model [64];       // what the pixel buffer should hold
  logic [31:0] rngState = 32'd42;
  bit          expQ [$];         // bits still expected on the line
  bit          gotQ [$];         // decoded bits waiting for the compare process
  bit          decodeOn = 1'b1;
  int          minGap;           // shortest low run seen between two frames
  int          frameBits = 24;   // bits in one frame of the running test
  int          decodedBits = 0;  // bits decoded since the strip was started
  int          checkedBits;
  int          errors = 0;
  int          testsFailed = 0;

  neoPixelTop uut (.clk(clk), .rst(rst), .hostIn(hostIn), .hostOut(hostOut), .neoData(neoData));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  function automatic logic [7:0] nextRandom();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState[7:0];
  endfunction

  // left-justify a packed field and repeat it until all 8 bits are filled
  function automatic logic [7:0] expandField(input logic [2:0] field, input int width);
    logic [7:0] r;
    for (int i = 0; i < 8; i++)
      r[3'(7 - i)] = field[2'(width - 1 - (i % width))];
    return r;
  endfunction

  // channel 0 is green, 1 red, 2 blue, as they go out on the wire
  function automatic logic [7:0] channelValue(input bit mode32, input int p, input int ch);
    logic [7:0] packedPix;
    packedPix = model[6'(p)];
    if (mode32) return model[6'(p * 4 + ch)]; // the fourth byte of a pixel is never sent
    case (ch)
      0:       return expandField(packedPix[5:3], 3);
      1:       return expandField(packedPix[2:0], 3);
      default: return expandField({1'b0, packedPix[7:6]}, 2);
    endcase
  endfunction

  // reference model, appends one whole frame to the expected bits, msb first
  function automatic void expectedBits(input bit mode32, input int lastPixel);
    logic [7:0] value;
    for (int p = 0; p <= lastPixel; p++) begin
      for (int ch = 0; ch < 3; ch++) begin
        value = channelValue(mode32, p, ch);
        for (int b = 7; b >= 0; b--)
          expQ.push_back(value[3'(b)]);
      end
    end
  endfunction

  task automatic checkValue(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got == exp) else begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // one four-phase access, ack is awaited and then must follow req down
  task automatic hostAccess(input logic we, input neoRegPkg::hostAddrT addr,
                            input logic [7:0] wdata, output logic [7:0] rdata);
    @(posedge clk);
    hostIn <= '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    do @(posedge clk); while (!hostOut.ack);
    rdata = hostOut.rdata;
    hostIn.req <= 1'b0;
    repeat (2) @(posedge clk); // ack drops one cycle after the DUT sees req low
    assert (!hostOut.ack) else begin
      errors++;
      $display("ack stayed high after req dropped at address %h", addr);
    end
  endtask

  task automatic fillRandom(input int count);
    logic [7:0] rd;
    for (int a = 0; a < count; a++) begin
      model[6'(a)] = nextRandom();
      hostAccess(1'b1, 7'(a), model[6'(a)], rd);
    end
  endtask

  // start the strip, wait until every expected bit was compared, then stop it in the gap
  task automatic runFrames(input bit mode32, input int lastPixel, input int frames);
    logic [7:0] rd;
    expQ.delete();
    gotQ.delete();
    checkedBits = 0;
    decodedBits = 0;
    frameBits = 24 * (lastPixel + 1); // three channels of eight bits per pixel
    minGap = 1 << 30;
    for (int f = 0; f < frames; f++)
      expectedBits(mode32, lastPixel);
    hostAccess(1'b1, neoRegPkg::lastPixelAddr, 8'(lastPixel), rd);
    hostAccess(1'b1, neoRegPkg::ctrlAddr, {6'b0, mode32, 1'b1}, rd);
    while (expQ.size() != 0) @(posedge clk);
    hostAccess(1'b1, neoRegPkg::ctrlAddr, {6'b0, mode32, 1'b0}, rd);
  endtask

  task automatic reportTest(input int num, input string name, input int errBefore);
    if (errors == errBefore) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      testsFailed++;
      $display("test %0d %s: failed with %0d errors", num, name, errors - errBefore);
    end
  endtask

  // samples the line at each rising edge, a high run of 5 is a one and 2 is a zero
  initial begin : decoder
    int highCnt;
    int lowCnt;
    highCnt = 0;
    lowCnt = 0;
    forever begin
      @(posedge clk);
      if (!decodeOn) begin
        highCnt = 0;
        lowCnt = 0;
      end else if (neoData) begin
        // the low run in front of the first bit of a later frame is the latch gap
        if (highCnt == 0 && decodedBits != 0 && decodedBits % frameBits == 0 &&
            lowCnt < minGap) begin
          minGap = lowCnt;
        end
        highCnt++;
        lowCnt = 0;
      end else begin
        lowCnt++;
        if (highCnt != 0) begin
          assert (highCnt == 5 || highCnt == 2) else begin
            errors++;
            $display("a high pulse of %0d cycles is neither a one nor a zero", highCnt);
          end
          gotQ.push_back(highCnt == 5);
          decodedBits++;
          highCnt = 0;
        end
      end
    end
  end

  initial begin : compare
    bit got;
    bit exp;
    forever begin
      @(posedge clk);
      while (gotQ.size() != 0) begin
        got = gotQ.pop_front();
        if (expQ.size() == 0) begin
          errors++;
          $display("neoData sent a bit after the expected frames had ended");
        end else begin
          exp = expQ.pop_front();
          checkValue($sformatf("neoData bit %0d", checkedBits), {7'b0, got}, {7'b0, exp});
          checkedBits++;
        end
      end
    end
  end

  initial begin : watchdog
    int limitNs;
    limitNs = 0;
    foreach (testPixels[i])
      limitNs += 4 * (neoTypesPkg::latchCycles + 192 * testPixels[i] + 1000);
    #(2 * limitNs);
    $display("timeout: the tests did not finish within %0d ns", 2 * limitNs);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [7:0] rd;
    logic [7:0] v;
    int errBefore;
    int highCount;
    rst = 1'b1;
    hostIn = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    errBefore = errors;
    highCount = 0;
    repeat (500) begin
      @(posedge clk);
      if (neoData || hostOut.ack) highCount++;
    end
    assert (highCount == 0) else begin
      errors++;
      $display("neoData or ack went high while run was clear");
    end
    reportTest(1, "idle after reset", errBefore);

    errBefore = errors;
    fillRandom(64);
    for (int a = 0; a < 64; a++) begin
      hostAccess(1'b0, 7'(a), 8'h00, rd);
      checkValue($sformatf("hostOut.rdata at %h", a), rd, model[6'(a)]);
    end
    v = nextRandom() & 8'h3f;
    hostAccess(1'b1, neoRegPkg::lastPixelAddr, v, rd);
    hostAccess(1'b0, neoRegPkg::lastPixelAddr, 8'h00, rd);
    checkValue("hostOut.rdata of lastPixel", rd, v);
    v = nextRandom() & 8'h02; // run stays clear so the strip does not start
    hostAccess(1'b1, neoRegPkg::ctrlAddr, v, rd);
    hostAccess(1'b0, neoRegPkg::ctrlAddr, 8'h00, rd);
    checkValue("hostOut.rdata of control", rd, v);
    reportTest(2, "register readback", errBefore);

    errBefore = errors;
    fillRandom(16);
    runFrames(1'b1, 3, 1);
    reportTest(3, "32-bit frame", errBefore);

    errBefore = errors;
    fillRandom(8);
    runFrames(1'b0, 7, 1);
    reportTest(4, "8-bit frame", errBefore);

    errBefore = errors;
    runFrames(1'b1, 1, 2); // reuses the bytes of the last fill
    assert (minGap >= neoTypesPkg::latchCycles) else begin
      errors++;
      $display("the low gap between frames lasted only %0d cycles", minGap);
    end
    reportTest(5, "two frames with latch gap", errBefore);

    errBefore = errors;
    decodeOn = 1'b0; // the cut-off pulse is not a valid bit
    hostAccess(1'b1, neoRegPkg::lastPixelAddr, 8'd15, rd);
    hostAccess(1'b1, neoRegPkg::ctrlAddr, 8'h03, rd);
    while (!neoData) @(posedge clk);
    repeat (100) @(posedge clk);
    hostAccess(1'b1, neoRegPkg::ctrlAddr, 8'h02, rd);
    highCount = 0;
    repeat (500) begin
      @(posedge clk);
      if (neoData && highCount < 255) highCount++; // saturates so it fits the 8-bit check
    end
    checkValue("neoData high cycles after stop", 8'(highCount), 8'h00);
    reportTest(6, "stop mid-frame", errBefore);

    $display("6 tests, %0d failed, %0d errors", testsFailed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
